/* design/oramCipher_defines.svh */
/*
 * ORAM cipher widths, depths and keystream constants
 */
`ifndef ORAM_CIPHER_DEFINES_SVH
`define ORAM_CIPHER_DEFINES_SVH

// Bus widths
`define BURST_WIDTH       64
`define MASK_WIDTH        8
`define IV_WIDTH          16
`define LANE_WIDTH        32

// Path geometry, in DRAM bursts
`define BUCKET_BURSTS     4
`define PATH_BURSTS       12

// Buffering and keystream pipeline
`define QUEUE_DEPTH       8
`define KEYSTREAM_STAGES  4
`define CIPHER_KEY        32'h5a17c3e1
`define ROUND_CONST       32'h9e3779b9

`endif

/* design/oramCipherPkg.sv */
/*
 * ORAM cipher shared types
 * Burst, mask and IV vectors, path direction and queue entry structs
 */
`include "oramCipher_defines.svh"

package oramCipherPkg;

    // ------------------------------------------------------------
    // Vector types
    // ------------------------------------------------------------
    typedef logic [`BURST_WIDTH-1:0]               burstT;
    typedef logic [`MASK_WIDTH-1:0]                maskT;
    typedef logic [`IV_WIDTH-1:0]                  ivT;
    typedef logic [`LANE_WIDTH-1:0]                laneT;
    typedef logic [$clog2(`BUCKET_BURSTS)-1:0]     burstIdxT;
    typedef logic [$clog2(`PATH_BURSTS)-1:0]       pathIdxT;

    // Which way the current path is moving
    typedef enum logic [1:0] {
        PathIdle,
        PathRead,
        PathWrite
    } pathDirT;

    // ------------------------------------------------------------
    // Structs
    // ------------------------------------------------------------
    // One queued burst, header flag marks burst 0 of a bucket
    typedef struct packed {
        burstT data;
        maskT  mask;
        logic  isHeader;
    } cipherEntryT;

    // Keystream request for one burst
    typedef struct packed {
        ivT       iv;
        burstIdxT burstIdx;
    } keystreamReqT;

endpackage

/* design/cipherQueue.sv */
/*
 * Synchronous in-order FIFO with a free flag for issue gating
 */
`timescale 1ns/10ps

module cipherQueue #(
    parameter int Width = 64,
    parameter int Depth = 8
) (
    input  logic             Clock,
    input  logic             reset,
    input  logic [Width-1:0] inData,
    input  logic             inValid,
    output logic [Width-1:0] outData,
    output logic             outValid,
    input  logic             outReady,
    output logic             free
);
    localparam int PtrWidth   = (Depth > 1) ? $clog2(Depth) : 1;
    localparam int CountWidth = $clog2(Depth + 1);

    logic [Width-1:0]      mem [Depth];
    logic [PtrWidth-1:0]   wrPtr;
    logic [PtrWidth-1:0]   rdPtr;
    logic [CountWidth-1:0] count;
    logic                  push;
    logic                  pop;

    // A write issued now is already counted next cycle
    assign free     = count < CountWidth'(Depth);
    assign outValid = count != '0;
    assign outData  = mem[rdPtr];
    assign push     = inValid & free;
    assign pop      = outValid & outReady;

    always_ff @(posedge Clock) begin
        if (reset) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= (wrPtr == PtrWidth'(Depth - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= (rdPtr == PtrWidth'(Depth - 1)) ? '0 : rdPtr + 1'b1;
            end
            count <= count + CountWidth'(push) - CountWidth'(pop);
        end
    end

    // Storage
    always_ff @(posedge Clock) begin
        if (push) begin
            mem[wrPtr] <= inData;
        end
    end

endmodule

/* design/bucketHeaderDecode.sv */
/*
 * Bucket header decode
 * Picks the burst source by direction, tracks bucket position and IV
 */
`timescale 1ns/10ps
`include "oramCipher_defines.svh"

module bucketHeaderDecode (
    input  logic                        Clock,
    input  logic                        reset,
    input  oramCipherPkg::burstT        MIGIn,
    input  logic                        MIGInValid,
    input  oramCipherPkg::burstT        BackendWData,
    input  oramCipherPkg::maskT         BackendWMask,
    input  logic                        BackendWValid,
    output logic                        BackendWReady,
    input  logic                        entryFree,
    input  oramCipherPkg::pathDirT      direction,
    output oramCipherPkg::cipherEntryT  entry,
    output logic                        entryValid,
    output oramCipherPkg::keystreamReqT req,
    output logic                        reqValid
);
    import oramCipherPkg::*;

    burstT    bufData;
    logic     bufValid;
    logic     bufReady;
    pathDirT  seenDirection;
    pathIdxT  pathCount;
    burstIdxT burstIdx;
    ivT       bucketIv;
    logic     pathDone;
    logic     canIssue;
    logic     issue;
    burstT    inBurst;
    logic     isHeader;

    // Path buffer, DRAM has no back-pressure so it holds a full path
    cipherQueue #(
        .Width(`BURST_WIDTH),
        .Depth(`PATH_BURSTS)
    ) pathBuffer (
        .Clock   (Clock),
        .reset   (reset),
        .inData  (MIGIn),
        .inValid (MIGInValid),
        .outData (bufData),
        .outValid(bufValid),
        .outReady(bufReady),
        .free    ()
    );

    // ------------------------------------------------------------
    // Issue control
    // ------------------------------------------------------------
    // Hold off for one cycle after a direction change
    assign pathDone      = pathCount == pathIdxT'(`PATH_BURSTS);
    assign canIssue      = entryFree & ~pathDone & (direction == seenDirection);
    assign bufReady      = canIssue & (direction == PathRead);
    assign BackendWReady = canIssue & (direction == PathWrite);
    assign issue         = (bufValid & bufReady) | (BackendWValid & BackendWReady);

    assign inBurst  = (direction == PathWrite) ? BackendWData : bufData;
    assign isHeader = burstIdx == '0;

    // Entry and request leave together
    assign entry.data     = inBurst;
    assign entry.mask     = (direction == PathWrite) ? BackendWMask : '0;
    assign entry.isHeader = isHeader;
    assign entryValid     = issue;

    // Header carries its own IV, later bursts use the latched one
    assign req.iv       = isHeader ? inBurst[`IV_WIDTH-1:0] : bucketIv;
    assign req.burstIdx = burstIdx;
    assign reqValid     = issue;

    always_ff @(posedge Clock) begin
        if (reset) begin
            seenDirection <= PathIdle;
            pathCount     <= '0;
            burstIdx      <= '0;
        end else if (direction != seenDirection) begin
            seenDirection <= direction;
            pathCount     <= '0;
            burstIdx      <= '0;
        end else if (issue) begin
            pathCount <= pathCount + 1'b1;
            burstIdx  <= (burstIdx == burstIdxT'(`BUCKET_BURSTS - 1)) ? '0 : burstIdx + 1'b1;
        end
    end

    // Bucket IV
    always_ff @(posedge Clock) begin
        if (issue && isHeader) begin
            bucketIv <= inBurst[`IV_WIDTH-1:0];
        end
    end

endmodule

/* design/keystreamPipeline.sv */
/*
 * Keystream pipeline
 * Fixed-latency keyed mixing of IV and burst index into two lanes
 */
`timescale 1ns/10ps
`include "oramCipher_defines.svh"

module keystreamPipeline (
    input  logic                        Clock,
    input  logic                        reset,
    input  oramCipherPkg::keystreamReqT req,
    input  logic                        reqValid,
    output oramCipherPkg::burstT        keystream,
    output logic                        keystreamValid
);
    import oramCipherPkg::*;

    localparam int Lanes = `BURST_WIDTH / `LANE_WIDTH;

    laneT                        seed     [Lanes];
    laneT                        stageLane[`KEYSTREAM_STAGES][Lanes];
    logic [`KEYSTREAM_STAGES-1:0] stageValid;

    // One mixing round
    function automatic laneT mixRound(input laneT lane);
        laneT keyed;
        keyed = lane ^ `CIPHER_KEY;
        return {keyed[`LANE_WIDTH-8:0], keyed[`LANE_WIDTH-1:`LANE_WIDTH-7]} + `ROUND_CONST;
    endfunction

    // Lane start is IV + 2 * burst index + lane number
    always_comb begin
        for (int l = 0; l < Lanes; l++) begin
            seed[l] = laneT'(req.iv) + laneT'({req.burstIdx, 1'b0}) + laneT'(l);
        end
    end

    // ------------------------------------------------------------
    // Stages
    // ------------------------------------------------------------
    always_ff @(posedge Clock) begin
        if (reset) begin
            stageValid <= '0;
        end else begin
            stageValid <= {stageValid[`KEYSTREAM_STAGES-2:0], reqValid};
        end
    end

    always_ff @(posedge Clock) begin
        for (int l = 0; l < Lanes; l++) begin
            stageLane[0][l] <= mixRound(seed[l]);
            for (int s = 1; s < `KEYSTREAM_STAGES; s++) begin
                stageLane[s][l] <= mixRound(stageLane[s-1][l]);
            end
        end
    end

    // Lane 1 in the upper half
    assign keystream      = {stageLane[`KEYSTREAM_STAGES-1][1],
                             stageLane[`KEYSTREAM_STAGES-1][0]};
    assign keystreamValid = stageValid[`KEYSTREAM_STAGES-1];

endmodule

/* design/cipherCombiner.sv */
/*
 * Cipher combiner
 * XORs data with keystream, restores header IV, runs path direction FSM
 */
`timescale 1ns/10ps
`include "oramCipher_defines.svh"

module cipherCombiner (
    input  logic                       Clock,
    input  logic                       reset,
    input  oramCipherPkg::cipherEntryT entry,
    input  logic                       entryValid,
    input  oramCipherPkg::burstT       keystream,
    input  logic                       keystreamValid,
    output logic                       entryFree,
    output oramCipherPkg::pathDirT     direction,
    output oramCipherPkg::burstT       MIGOut,
    output oramCipherPkg::maskT        MIGOutMask,
    output logic                       MIGOutValid,
    input  logic                       MIGOutReady,
    output oramCipherPkg::burstT       BackendRData,
    output logic                       BackendRValid,
    input  logic                       DRAMInitDone
);
    import oramCipherPkg::*;

    cipherEntryT headEntry;
    logic        headValid;
    logic        dataFree;
    burstT       headKey;
    logic        keyValid;
    burstT       xorRes;
    burstT       result;
    logic        resultValid;
    logic        resultReady;
    logic        pop;
    logic        lastResult;
    pathIdxT     resultCount;

    // ------------------------------------------------------------
    // Data and keystream queues
    // ------------------------------------------------------------
    cipherQueue #(.Width($bits(cipherEntryT)), .Depth(`QUEUE_DEPTH)) dataQueue (
        .Clock   (Clock),
        .reset   (reset),
        .inData  (entry),
        .inValid (entryValid),
        .outData (headEntry),
        .outValid(headValid),
        .outReady(pop),
        .free    (dataFree)
    );

    cipherQueue #(.Width(`BURST_WIDTH), .Depth(`QUEUE_DEPTH)) keyQueue (
        .Clock   (Clock),
        .reset   (reset),
        .inData  (keystream),
        .inValid (keystreamValid),
        .outData (headKey),
        .outValid(keyValid),
        .outReady(pop),
        .free    ()
    );

    // Every keystream in flight already has its entry in the data queue
    assign entryFree = dataFree;

    // ------------------------------------------------------------
    // XOR and routing
    // ------------------------------------------------------------
    assign xorRes = headEntry.data ^ headKey;
    assign result = headEntry.isHeader ?
                    {xorRes[`BURST_WIDTH-1:`IV_WIDTH], headEntry.data[`IV_WIDTH-1:0]} : xorRes;

    assign resultValid = headValid & keyValid & (direction != PathIdle);
    // Reads never stall
    assign resultReady = (direction == PathRead) | ((direction == PathWrite) & MIGOutReady);
    assign pop         = resultValid & resultReady;

    assign MIGOut        = result;
    assign MIGOutMask    = headEntry.mask;
    assign MIGOutValid   = resultValid & (direction == PathWrite);
    assign BackendRData  = result;
    assign BackendRValid = resultValid & (direction == PathRead);

    // Path FSM
    assign lastResult = pop & (resultCount == pathIdxT'(`PATH_BURSTS - 1));

    always_ff @(posedge Clock) begin
        if (reset) begin
            direction   <= PathIdle;
            resultCount <= '0;
        end else begin
            if (lastResult) begin
                resultCount <= '0;
            end else if (pop) begin
                resultCount <= resultCount + 1'b1;
            end
            case (direction)
                PathIdle:  if (DRAMInitDone) direction <= PathRead;
                PathRead:  if (lastResult) direction <= PathWrite;
                PathWrite: if (lastResult) direction <= PathRead;
                default:   direction <= PathIdle;
            endcase
        end
    end

endmodule

/* design/pathOramCipher.sv */
/*
 * Path ORAM cipher layer between the ORAM backend and DRAM
 */
`timescale 1ns/10ps

module pathOramCipher (
    input  logic                 Clock,
    input  logic                 reset,
    input  oramCipherPkg::burstT MIGIn,
    input  logic                 MIGInValid,
    output oramCipherPkg::burstT MIGOut,
    output oramCipherPkg::maskT  MIGOutMask,
    output logic                 MIGOutValid,
    input  logic                 MIGOutReady,
    input  oramCipherPkg::burstT BackendWData,
    input  oramCipherPkg::maskT  BackendWMask,
    input  logic                 BackendWValid,
    output logic                 BackendWReady,
    output oramCipherPkg::burstT BackendRData,
    output logic                 BackendRValid,
    input  logic                 DRAMInitDone
);
    import oramCipherPkg::*;

    cipherEntryT  entry;
    logic         entryValid;
    keystreamReqT req;
    logic         reqValid;
    burstT        keystream;
    logic         keystreamValid;
    logic         entryFree;
    pathDirT      direction;

    bucketHeaderDecode decode (
        .Clock        (Clock),
        .reset        (reset),
        .MIGIn        (MIGIn),
        .MIGInValid   (MIGInValid),
        .BackendWData (BackendWData),
        .BackendWMask (BackendWMask),
        .BackendWValid(BackendWValid),
        .BackendWReady(BackendWReady),
        .entryFree    (entryFree),
        .direction    (direction),
        .entry        (entry),
        .entryValid   (entryValid),
        .req          (req),
        .reqValid     (reqValid)
    );

    keystreamPipeline execute (
        .Clock         (Clock),
        .reset         (reset),
        .req           (req),
        .reqValid      (reqValid),
        .keystream     (keystream),
        .keystreamValid(keystreamValid)
    );

    cipherCombiner combiner (
        .Clock         (Clock),
        .reset         (reset),
        .entry         (entry),
        .entryValid    (entryValid),
        .keystream     (keystream),
        .keystreamValid(keystreamValid),
        .entryFree     (entryFree),
        .direction     (direction),
        .MIGOut        (MIGOut),
        .MIGOutMask    (MIGOutMask),
        .MIGOutValid   (MIGOutValid),
        .MIGOutReady   (MIGOutReady),
        .BackendRData  (BackendRData),
        .BackendRValid (BackendRValid),
        .DRAMInitDone  (DRAMInitDone)
    );

endmodule

/* verification/cipherModel.svh */
/*
 * Cipher reference model
 * Keystream and expected bursts for one path, plus typed result compares
 */
`ifndef CIPHER_MODEL_SVH
`define CIPHER_MODEL_SVH

// One keystream lane after all mixing stages
function automatic laneT modelLane(input ivT iv, input burstIdxT idx, input int lane);
    laneT value;
    value = laneT'(iv) + laneT'(2 * int'(idx)) + laneT'(lane);
    for (int r = 0; r < `KEYSTREAM_STAGES; r++) begin
        value = value ^ `CIPHER_KEY;
        value = (value << 7) | (value >> (`LANE_WIDTH - 7));
        value = value + `ROUND_CONST;
    end
    return value;
endfunction

// Lane 1 sits in the upper half of the burst
function automatic burstT modelKeystream(input ivT iv, input burstIdxT idx);
    return {modelLane(iv, idx, 1), modelLane(iv, idx, 0)};
endfunction

// ------------------------------------------------------------
// Expected results for the path held in pathData and pathMask
// ------------------------------------------------------------
task automatic expectPath();
    ivT       iv;
    burstIdxT idx;
    burstT    expected;
    iv = '0;
    for (int i = 0; i < `PATH_BURSTS; i++) begin
        idx = burstIdxT'(i % `BUCKET_BURSTS);
        // Header IV stays in plain text
        if (idx == '0) begin
            iv = pathData[i][`IV_WIDTH-1:0];
        end
        expected = pathData[i] ^ modelKeystream(iv, idx);
        if (idx == '0) begin
            expected[`IV_WIDTH-1:0] = iv;
        end
        expData.push_back(expected);
        expMask.push_back(pathMask[i]);
    end
endtask

task automatic checkBurst(input string name, input burstT expected, input burstT actual);
    checks++;
    if (expected !== actual) begin
        errors++;
        $display("** Error %s: expected data %h, actual %h", name, expected, actual);
    end
endtask

task automatic checkMask(input string name, input maskT expected, input maskT actual);
    checks++;
    if (expected !== actual) begin
        errors++;
        $display("** Error %s: expected mask %h, actual %h", name, expected, actual);
    end
endtask

`endif

/* verification/pathOramCipherTb.sv */
/*
 * Testbench for the Path ORAM cipher layer
 * Alternating random read and write paths checked against a keystream model
 */
`timescale 1ns/10ps
`include "oramCipher_defines.svh"

module pathOramCipherTb;
    import oramCipherPkg::*;

    // Six paths with generous slack per burst
    localparam int TimeoutCycles = 6 * `PATH_BURSTS * 30 + 200;

    logic   Clock;
    logic   reset;
    burstT  MIGIn;
    logic   MIGInValid;
    burstT  MIGOut;
    maskT   MIGOutMask;
    logic   MIGOutValid;
    logic   MIGOutReady;
    burstT  BackendWData;
    maskT   BackendWMask;
    logic   BackendWValid;
    logic   BackendWReady;
    burstT  BackendRData;
    logic   BackendRValid;
    logic   DRAMInitDone;

    integer seed = 32'h475b;
    int     errors;
    int     checks;
    int     testCount;
    int     cycleCount;
    burstT  pathData[`PATH_BURSTS];
    maskT   pathMask[`PATH_BURSTS];
    burstT  expData[$];
    maskT   expMask[$];

    `include "cipherModel.svh"

    pathOramCipher pathOramCipher_i (
        .Clock        (Clock),
        .reset        (reset),
        .MIGIn        (MIGIn),
        .MIGInValid   (MIGInValid),
        .MIGOut       (MIGOut),
        .MIGOutMask   (MIGOutMask),
        .MIGOutValid  (MIGOutValid),
        .MIGOutReady  (MIGOutReady),
        .BackendWData (BackendWData),
        .BackendWMask (BackendWMask),
        .BackendWValid(BackendWValid),
        .BackendWReady(BackendWReady),
        .BackendRData (BackendRData),
        .BackendRValid(BackendRValid),
        .DRAMInitDone (DRAMInitDone)
    );

    always #4 Clock = ~Clock;

    // Watchdog
    always @(posedge Clock) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TimeoutCycles) begin
            $display("Timeout after %0d cycles, the DUT stopped delivering results", cycleCount);
            $display("Finished with errors");
            $finish;
        end
    end

    task automatic reportTest(input string name, input int nChecks, input int nErrors);
        testCount++;
        $display("%-18s %0d checks, %0d failed", name, nChecks, nErrors);
    endtask

    task automatic fillPath();
        for (int i = 0; i < `PATH_BURSTS; i++) begin
            pathData[i] = {$random(seed), $random(seed)};
            pathMask[i] = maskT'($random(seed));
        end
    endtask

    // Pops the next expected result and compares it
    task automatic takeResult(input string name, input burstT data, input maskT mask,
                              input logic withMask);
        burstT expectedData;
        maskT  expectedMask;
        expectedData = expData.pop_front();
        expectedMask = expMask.pop_front();
        checkBurst(name, expectedData, data);
        if (withMask) begin
            checkMask(name, expectedMask, mask);
        end
    endtask

    task automatic idleAfterReset();
        int e0;
        e0 = errors;
        repeat (20) begin
            @(negedge Clock);
            checks++;
            if (BackendRValid || MIGOutValid || BackendWReady) begin
                errors++;
                $display("idle after reset: a strobe went high before DRAM init was done");
            end
        end
        reportTest("idle after reset", 20, errors - e0);
    endtask

    // ------------------------------------------------------------
    // Read path, DRAM strobes bursts in with random gaps
    // ------------------------------------------------------------
    task automatic runReadPath(input int n);
        string name;
        int    c0;
        int    e0;
        int    sent;
        int    got;
        name = $sformatf("read path %0d", n);
        c0 = checks;
        e0 = errors;
        sent = 0;
        got = 0;
        fillPath();
        expectPath();
        while (got < `PATH_BURSTS) begin
            @(negedge Clock);
            if (sent < `PATH_BURSTS && ($random(seed) & 3) != 0) begin
                MIGIn = pathData[sent];
                MIGInValid = 1'b1;
                sent++;
            end else begin
                MIGInValid = 1'b0;
            end
            if (BackendRValid) begin
                takeResult(name, BackendRData, '0, 1'b0);
                got++;
            end
            if (MIGOutValid) begin
                errors++;
                $display("%s: a MIGOut result appeared during a read path", name);
            end
        end
        MIGInValid = 1'b0;
        reportTest(name, checks - c0, errors - e0);
    endtask

    // ------------------------------------------------------------
    // Write path with random DRAM back-pressure
    // ------------------------------------------------------------
    task automatic runWritePath(input int n);
        string name;
        int    c0;
        int    e0;
        int    sent;
        int    got;
        logic  wXfer;
        name = $sformatf("write path %0d", n);
        c0 = checks;
        e0 = errors;
        sent = 0;
        got = 0;
        wXfer = 1'b0;
        fillPath();
        expectPath();
        while (got < `PATH_BURSTS) begin
            @(negedge Clock);
            if (wXfer) begin
                sent++;
            end
            // Valid holds until the burst is taken
            if (sent >= `PATH_BURSTS) begin
                BackendWValid = 1'b0;
            end else if (!BackendWValid || wXfer) begin
                BackendWData = pathData[sent];
                BackendWMask = pathMask[sent];
                BackendWValid = ($random(seed) & 3) != 0;
            end
            wXfer = BackendWValid && BackendWReady;
            MIGOutReady = ($random(seed) & 1) != 0;
            if (MIGOutValid && MIGOutReady) begin
                takeResult(name, MIGOut, MIGOutMask, 1'b1);
                got++;
            end
            if (BackendRValid) begin
                errors++;
                $display("%s: a BackendR result appeared during a write path", name);
            end
        end
        BackendWValid = 1'b0;
        reportTest(name, checks - c0, errors - e0);
    endtask

    initial begin
        int c0;
        int e0;
        Clock = 1'b0;
        reset = 1'b1;
        cycleCount = 0;
        MIGIn = '0;
        MIGInValid = 1'b0;
        MIGOutReady = 1'b0;
        BackendWData = '0;
        BackendWMask = '0;
        BackendWValid = 1'b0;
        DRAMInitDone = 1'b0;
        repeat (5) @(negedge Clock);
        reset = 1'b0;

        idleAfterReset();
        DRAMInitDone = 1'b1;
        for (int p = 1; p <= 3; p++) begin
            runReadPath(p);
            runWritePath(p);
        end

        // Nothing more may come out once the last write has drained
        c0 = checks;
        e0 = errors;
        repeat (20) begin
            @(negedge Clock);
            checks++;
            if (BackendRValid || MIGOutValid) begin
                errors++;
                $display("alternation: a result appeared with no path in progress");
            end
        end
        reportTest("alternation", checks - c0, errors - e0);

        $display("Summary: %0d tests, %0d checks, %0d errors", testCount, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* src.f */
+incdir+design
+incdir+verification
design/oramCipherPkg.sv
design/cipherQueue.sv
design/bucketHeaderDecode.sv
design/keystreamPipeline.sv
design/cipherCombiner.sv
design/pathOramCipher.sv
verification/pathOramCipherTb.sv

/* Makefile */
TOP = pathOramCipherTb

all: build
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "Finished with no errors"

build:
	verilator --binary --timing --timescale 1ns/10ps -Wno-fatal -f src.f --top-module $(TOP)

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/10ps -f src.f --top-module pathOramCipher

clean:
	rm -rf obj_dir

.PHONY: all build lint clean
